//--- Makefile
# Verilator build and run for the LED matrix driver testbench

VERILATOR ?= verilator
TOP       ?= led_matrix_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  := ALL CHECKS PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard common/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || { echo "simulation did not pass"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- common/led_matrix_config.svh
/*
 * panel geometry, brightness planes, serial bit rate and scan timing
 */
`ifndef LED_MATRIX_CONFIG_SVH
`define LED_MATRIX_CONFIG_SVH

// panel geometry
`define LM_WIDTH        16
`define LM_HEIGHT       8
`define LM_HALF_HEIGHT  4   // rows per scanned half

// two bits per channel, one plane per bit
`define LM_PLANES       2

// serial input, clk_root cycles per bit
`define LM_TICKS_PER_BIT 8

// clk_root cycles per scan tick
// must cover the 3 cycle fetch latency plus one
`define LM_SCAN_DIV     4

// output enable ticks for plane 0, doubled per plane
`define LM_SHOW_BASE    8

`endif

//--- common/led_matrix_pkg.sv
/*
 * width typedefs and FSM state enums for the LED matrix driver
 */
`default_nettype none

package led_matrix_pkg;

    typedef logic [7:0] pixel_t;       // {unused, b[1:0], g[1:0], r[1:0]}
    typedef logic [3:0] col_addr_t;
    typedef logic [1:0] row_addr_t;    // row within one half
    typedef logic [6:0] fb_addr_t;     // full row * width + column
    typedef logic [2:0] rgb_t;         // red in bit 0
    typedef logic [1:0] plane_mask_t;

    typedef enum logic [2:0] {
        IDLE,
        ROW_INDEX,
        ROW_DATA,
        SET_BRIGHTNESS,
        SET_RGB
    } cmd_state_t;

    typedef enum logic [1:0] {
        SHIFT,
        LATCH,
        SHOW
    } scan_state_t;

endpackage

`default_nettype wire

//--- control/command_decoder.sv
/*
 * serial command parser, frame buffer row writes and enable registers
 */
`timescale 1ns/1ps
`default_nettype none

`include "led_matrix_config.svh"

module command_decoder import led_matrix_pkg::*; (
    input  logic        clk_root,
    input  logic        arst_n,
    input  pixel_t      rx_byte,
    input  logic        rx_valid,
    output logic        fb_wr_en,
    output fb_addr_t    fb_wr_addr,
    output pixel_t      fb_wr_data,
    output rgb_t        rgb_enable,
    output plane_mask_t brightness_enable
);

    localparam pixel_t CMD_ROW        = 8'h4C;
    localparam pixel_t CMD_BRIGHTNESS = 8'h62;
    localparam pixel_t CMD_RGB        = 8'h63;

    localparam int ROW_W = $clog2(`LM_HEIGHT);

    cmd_state_t       state_q;
    logic [ROW_W-1:0] row_q;    // full panel row
    col_addr_t        col_q;
    logic             row_wr;

    assign row_wr = rx_valid && state_q == ROW_DATA;

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            state_q           <= IDLE;
            row_q             <= '0;
            col_q             <= '0;
            fb_wr_en          <= 1'b0;
            rgb_enable        <= '1;
            brightness_enable <= '1;
        end else begin
            fb_wr_en <= row_wr;
            if (rx_valid) begin
                case (state_q)
                    IDLE: begin
                        col_q <= '0;
                        case (rx_byte)
                            CMD_ROW:        state_q <= ROW_INDEX;
                            CMD_BRIGHTNESS: state_q <= SET_BRIGHTNESS;
                            CMD_RGB:        state_q <= SET_RGB;
                            default:        state_q <= IDLE;   // stray byte
                        endcase
                    end
                    ROW_INDEX: begin
                        if (rx_byte < pixel_t'(`LM_HEIGHT)) begin
                            row_q   <= rx_byte[ROW_W-1:0];
                            state_q <= ROW_DATA;
                        end else begin
                            state_q <= IDLE;   // out of range, abandon
                        end
                    end
                    ROW_DATA: begin
                        col_q <= col_q + 1'b1;
                        if (col_q == col_addr_t'(`LM_WIDTH - 1)) begin
                            state_q <= IDLE;
                        end
                    end
                    SET_BRIGHTNESS: begin
                        brightness_enable <= rx_byte[1:0];
                        state_q           <= IDLE;
                    end
                    SET_RGB: begin
                        rgb_enable <= rx_byte[2:0];
                        state_q    <= IDLE;
                    end
                    default: state_q <= IDLE;
                endcase
            end
        end
    end

    // write lands the cycle after its byte
    always_ff @(posedge clk_root) begin
        if (row_wr) begin
            fb_wr_addr <= fb_addr_t'(row_q) * fb_addr_t'(`LM_WIDTH) + fb_addr_t'(col_q);
            fb_wr_data <= rx_byte;
        end
    end

endmodule

`default_nettype wire

//--- dv/led_matrix_asserts.sv
/*
 * concurrent checks on the panel control outputs, bound into the top level
 */
`timescale 1ns/1ps
`default_nettype none

module led_matrix_asserts (
    input logic clk_root,
    input logic arst_n,
    input logic clk_pixel,
    input logic row_latch,
    input logic oe_n
);

    int fail_count = 0;   // read back by the testbench at the end

    // panel must be dark while columns shift in
    blank_on_pixel_clock: assert property (@(posedge clk_root) disable iff (!arst_n)
        clk_pixel |-> oe_n)
        else begin
            $error("oe_n low while clk_pixel high");
            fail_count++;
        end

    latch_one_cycle: assert property (@(posedge clk_root) disable iff (!arst_n)
        row_latch |=> !row_latch)
        else begin
            $error("row_latch held longer than one cycle");
            fail_count++;
        end

    blank_on_latch: assert property (@(posedge clk_root) disable iff (!arst_n)
        row_latch |-> oe_n)
        else begin
            $error("oe_n low during row_latch");
            fail_count++;
        end

endmodule

bind led_matrix_top led_matrix_asserts asserts_i (
    .clk_root  (clk_root),
    .arst_n    (arst_n),
    .clk_pixel (clk_pixel),
    .row_latch (row_latch),
    .oe_n      (oe_n)
);

`default_nettype wire

//--- dv/led_matrix_tb.sv
/*
 * testbench for the LED matrix driver, serial command stimulus,
 * panel shift model and colour checks per latched row
 */
`timescale 1ns/1ps
`default_nettype none

`include "led_matrix_config.svh"

module led_matrix_tb;

    localparam int FB_SIZE       = `LM_WIDTH * `LM_HEIGHT;
    localparam int LATCH_TIMEOUT = 1000;   // clk_root cycles per latch wait
    localparam logic [7:0] OP_ROW        = 8'h4C;
    localparam logic [7:0] OP_BRIGHTNESS = 8'h62;
    localparam logic [7:0] OP_RGB        = 8'h63;

    logic       clk_root;
    logic       arst_n;
    logic       uart_rxd;
    logic [2:0] rgb_top;
    logic [2:0] rgb_bottom;
    logic [1:0] row_addr;
    logic       clk_pixel;
    logic       row_latch;
    logic       oe_n;

    // panel model
    logic [7:0] frame [FB_SIZE];
    logic [2:0] rgb_en;
    logic [1:0] bright_en;
    logic [2:0] shift_top [$];
    logic [2:0] shift_bot [$];
    int         latch_count;
    int         pix_count;
    int         dark_count;   // oe_n low cycles since the last latch
    logic       pix_prev;
    logic       check_en;
    int         errors;
    int         timeouts;
    integer     seed;

    led_matrix_top dut_i (
        .clk_root   (clk_root),
        .arst_n     (arst_n),
        .uart_rxd   (uart_rxd),
        .rgb_top    (rgb_top),
        .rgb_bottom (rgb_bottom),
        .row_addr   (row_addr),
        .clk_pixel  (clk_pixel),
        .row_latch  (row_latch),
        .oe_n       (oe_n)
    );

    initial begin
        clk_root = 1'b0;
        forever #4 clk_root = ~clk_root;
    end

    task automatic finish_run();
        $display("errors %0d, timeouts %0d, assertion failures %0d",
                 errors, timeouts, dut_i.asserts_i.fail_count);
        if (errors == 0 && timeouts == 0 && dut_i.asserts_i.fail_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    task automatic check_value(input string name, input logic [7:0] got,
                               input logic [7:0] exp);
        assert (got === exp) else begin
            $display("error %s: got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    // channel c of plane p is pixel bit 2c+p, gated by both masks
    function automatic logic [2:0] expect_colour(input logic [7:0] px, input int plane);
        logic [2:0] res;
        for (int c = 0; c < 3; c++) begin
            res[c] = px[2*c + plane] & rgb_en[c] & bright_en[plane];
        end
        return res;
    endfunction

    task automatic check_latch();
        int plane;
        int row;
        plane = latch_count % `LM_PLANES;
        row   = (latch_count / `LM_PLANES) % `LM_HALF_HEIGHT;
        assert (pix_count == `LM_WIDTH) else begin
            $display("clk_pixel rose %0d times before latch %0d instead of %0d",
                     pix_count, latch_count, `LM_WIDTH);
            errors++;
        end
        // show time of the previous step, weighted by its plane
        if (latch_count > 0) begin
            check_value("oe_n low cycles", 8'(dark_count),
                        8'((`LM_SHOW_BASE << ((latch_count - 1) % `LM_PLANES))
                           * `LM_SCAN_DIV));
        end
        if (check_en) begin
            check_value("row_addr", 8'(row_addr), 8'(row));
            for (int k = 0; k < shift_top.size() && k < `LM_WIDTH; k++) begin
                check_value($sformatf("rgb_top col %0d", k), 8'(shift_top[k]),
                            8'(expect_colour(frame[row * `LM_WIDTH + k], plane)));
                check_value($sformatf("rgb_bottom col %0d", k), 8'(shift_bot[k]),
                            8'(expect_colour(frame[(row + `LM_HALF_HEIGHT) * `LM_WIDTH + k],
                                             plane)));
            end
        end
    endtask

    // outputs sampled mid-cycle, away from the driving edge
    always @(negedge clk_root) begin
        if (arst_n) begin
            if (clk_pixel && !pix_prev) begin
                shift_top.push_back(rgb_top);
                shift_bot.push_back(rgb_bottom);
                pix_count++;
            end
            if (!oe_n) begin
                dark_count++;
            end
            if (row_latch) begin
                check_latch();
                latch_count++;
                pix_count  = 0;
                dark_count = 0;
                shift_top.delete();
                shift_bot.delete();
            end
        end
        pix_prev = clk_pixel;
    end

    task automatic send_byte(input logic [7:0] b);
        logic [9:0] bits;
        bits = {1'b1, b, 1'b0};   // stop, data lsb first, start
        for (int i = 0; i < 10; i++) begin
            @(posedge clk_root);
            #1 uart_rxd = bits[i];
            repeat (`LM_TICKS_PER_BIT - 1) @(posedge clk_root);
        end
    endtask

    task automatic send_row(input int row);
        logic [7:0] px;
        send_byte(OP_ROW);
        send_byte(8'(row));
        for (int k = 0; k < `LM_WIDTH; k++) begin
            px = 8'($random(seed));
            frame[row * `LM_WIDTH + k] = px;
            send_byte(px);
        end
    endtask

    task automatic set_rgb_mask(input logic [2:0] m);
        send_byte(OP_RGB);
        send_byte({5'b0, m});
        rgb_en = m;
    endtask

    task automatic set_plane_mask(input logic [1:0] m);
        send_byte(OP_BRIGHTNESS);
        send_byte({6'b0, m});
        bright_en = m;
    endtask

    task automatic wait_latches(input int n);
        int seen;
        int waited;
        seen   = 0;
        waited = 0;
        while (seen < n && waited < LATCH_TIMEOUT) begin
            @(negedge clk_root);
            waited++;
            if (row_latch) begin
                seen++;
                waited = 0;
            end
        end
        if (seen < n) begin
            $display("timeout: no row_latch pulse within %0d cycles", LATCH_TIMEOUT);
            timeouts++;
        end
    endtask

    // skip the row in flight, then compare a number of latched rows
    task automatic scan_and_check(input int latches);
        repeat (4) @(posedge clk_root);
        wait_latches(1);
        @(posedge clk_root);
        check_en = 1'b1;
        wait_latches(latches);
        @(posedge clk_root);
        check_en = 1'b0;
    endtask

    task automatic check_idle_after_reset();
        int waited;
        check_value("oe_n", 8'(oe_n), 8'h1);
        check_value("clk_pixel", 8'(clk_pixel), 8'h0);
        check_value("row_latch", 8'(row_latch), 8'h0);
        check_value("row_addr", 8'(row_addr), 8'h0);
        check_value("rgb_top", 8'(rgb_top), 8'h0);
        check_value("rgb_bottom", 8'(rgb_bottom), 8'h0);
        waited = 0;
        while (!clk_pixel && waited < 64) begin
            @(negedge clk_root);
            waited++;
            check_value("oe_n", 8'(oe_n), 8'h1);
            check_value("row_latch", 8'(row_latch), 8'h0);
        end
        if (!clk_pixel) begin
            $display("timeout: clk_pixel never rose after reset");
            timeouts++;
        end
    endtask

    initial begin
        logic [7:0] stray;
        logic [2:0] rgb_mask;
        logic [1:0] plane_en;
        int         row;
        seed        = 32'h9ac6_b7ff;
        arst_n      = 1'b0;
        uart_rxd    = 1'b1;
        rgb_en      = 3'b111;
        bright_en   = 2'b11;
        latch_count = 0;
        pix_count   = 0;
        dark_count  = 0;
        pix_prev    = 1'b0;
        check_en    = 1'b0;
        errors      = 0;
        timeouts    = 0;
        repeat (2) @(posedge clk_root);
        #1 arst_n = 1'b1;
        check_idle_after_reset();

        for (int r = 0; r < `LM_HEIGHT; r++) begin
            send_row(r);
        end
        scan_and_check(16);   // two full frames

        rgb_mask = 3'($random(seed));
        if (rgb_mask == 3'b111) begin
            rgb_mask = 3'b110;   // at least one channel off
        end
        set_rgb_mask(rgb_mask);
        scan_and_check(16);
        plane_en = 2'($random(seed));
        if (plane_en == 2'b11) begin
            plane_en = 2'b10;   // at least one plane off
        end
        set_plane_mask(plane_en);
        scan_and_check(16);
        set_rgb_mask(3'b111);
        set_plane_mask(2'b11);

        // junk byte, then a row command with a bad index
        stray = 8'($random(seed));
        if (stray == OP_ROW || stray == OP_BRIGHTNESS || stray == OP_RGB) begin
            stray = stray ^ 8'h80;
        end
        send_byte(stray);
        send_byte(OP_ROW);
        send_byte(8'($random(seed)) | 8'h08);
        scan_and_check(8);
        row = $random(seed) & 32'h7;
        send_row(row);
        scan_and_check(16);

        finish_run();
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+common
common/led_matrix_pkg.sv
logic/uart_rx.sv
control/command_decoder.sv
logic/frame_buffer.sv
scan/matrix_scan.sv
scan/pixel_fetch.sv
logic/led_matrix_top.sv
dv/led_matrix_asserts.sv
dv/led_matrix_tb.sv

//--- logic/frame_buffer.sv
/*
 * single frame of pixel bytes, one write port and one registered read port
 */
`timescale 1ns/1ps
`default_nettype none

`include "led_matrix_config.svh"

module frame_buffer import led_matrix_pkg::*; (
    input  logic     clk_root,
    input  logic     wr_en,
    input  fb_addr_t wr_addr,
    input  pixel_t   wr_data,
    input  logic     rd_en,
    input  fb_addr_t rd_addr,
    output pixel_t   rd_data
);

    localparam int DEPTH = `LM_WIDTH * `LM_HEIGHT;

    pixel_t mem [DEPTH];

    always_ff @(posedge clk_root) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge clk_root) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];   // one cycle read latency
        end
    end

endmodule

`default_nettype wire

//--- logic/led_matrix_top.sv
/*
 * LED matrix driver top, serial receiver, decoder, frame buffer, scan and fetch
 */
`timescale 1ns/1ps
`default_nettype none

module led_matrix_top import led_matrix_pkg::*; (
    input  logic      clk_root,
    input  logic      arst_n,
    input  logic      uart_rxd,
    output rgb_t      rgb_top,
    output rgb_t      rgb_bottom,
    output row_addr_t row_addr,
    output logic      clk_pixel,
    output logic      row_latch,
    output logic      oe_n
);

    pixel_t      rx_byte;
    logic        rx_valid;
    logic        fb_wr_en;
    fb_addr_t    fb_wr_addr;
    pixel_t      fb_wr_data;
    rgb_t        rgb_enable;
    plane_mask_t brightness_enable;
    logic        load_start;
    col_addr_t   load_col;
    row_addr_t   scan_row;
    plane_mask_t plane_mask;
    logic        fb_rd_en;
    fb_addr_t    fb_rd_addr;
    pixel_t      fb_rd_data;

    uart_rx uart_rx_i (
        .clk_root (clk_root),
        .arst_n   (arst_n),
        .rxd      (uart_rxd),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid)
    );

    command_decoder command_decoder_i (
        .clk_root          (clk_root),
        .arst_n            (arst_n),
        .rx_byte           (rx_byte),
        .rx_valid          (rx_valid),
        .fb_wr_en          (fb_wr_en),
        .fb_wr_addr        (fb_wr_addr),
        .fb_wr_data        (fb_wr_data),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable)
    );

    frame_buffer frame_buffer_i (
        .clk_root (clk_root),
        .wr_en    (fb_wr_en),
        .wr_addr  (fb_wr_addr),
        .wr_data  (fb_wr_data),
        .rd_en    (fb_rd_en),
        .rd_addr  (fb_rd_addr),
        .rd_data  (fb_rd_data)
    );

    matrix_scan matrix_scan_i (
        .clk_root   (clk_root),
        .arst_n     (arst_n),
        .load_start (load_start),
        .load_col   (load_col),
        .scan_row   (scan_row),
        .plane_mask (plane_mask),
        .clk_pixel  (clk_pixel),
        .row_latch  (row_latch),
        .oe_n       (oe_n),
        .row_addr   (row_addr)
    );

    pixel_fetch pixel_fetch_i (
        .clk_root          (clk_root),
        .arst_n            (arst_n),
        .load_start        (load_start),
        .load_col          (load_col),
        .scan_row          (scan_row),
        .plane_mask        (plane_mask),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable),
        .fb_rd_en          (fb_rd_en),
        .fb_rd_addr        (fb_rd_addr),
        .fb_rd_data        (fb_rd_data),
        .rgb_top           (rgb_top),
        .rgb_bottom        (rgb_bottom)
    );

endmodule

`default_nettype wire

//--- logic/uart_rx.sv
/*
 * 8N1 serial receiver with a two flop input synchronizer
 */
`timescale 1ns/1ps
`default_nettype none

`include "led_matrix_config.svh"

module uart_rx import led_matrix_pkg::*; (
    input  logic   clk_root,
    input  logic   arst_n,
    input  logic   rxd,
    output pixel_t rx_byte,
    output logic   rx_valid
);

    localparam int TICK_W = $clog2(`LM_TICKS_PER_BIT);

    logic [1:0]        sync_q;
    logic              rxd_s;
    logic              busy_q;
    logic [TICK_W-1:0] tick_q;
    logic [3:0]        bit_q;    // 0 start, 1..8 data, 9 stop
    pixel_t            shift_q;

    assign rxd_s = sync_q[1];

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            sync_q   <= 2'b11;   // line idles high
            busy_q   <= 1'b0;
            tick_q   <= '0;
            bit_q    <= '0;
            rx_valid <= 1'b0;
        end else begin
            sync_q   <= {sync_q[0], rxd};
            rx_valid <= 1'b0;
            if (!busy_q) begin
                if (!rxd_s) begin   // start edge, aim for mid bit
                    busy_q <= 1'b1;
                    tick_q <= TICK_W'(`LM_TICKS_PER_BIT / 2 - 1);
                    bit_q  <= '0;
                end
            end else if (tick_q != '0) begin
                tick_q <= tick_q - 1'b1;
            end else begin
                tick_q <= TICK_W'(`LM_TICKS_PER_BIT - 1);
                bit_q  <= bit_q + 1'b1;
                if (bit_q == 4'd0 && rxd_s) begin
                    busy_q <= 1'b0;             // glitch, not a start bit
                end else if (bit_q == 4'd9) begin
                    busy_q   <= 1'b0;
                    rx_valid <= rxd_s;          // framing error drops the byte
                end
            end
        end
    end

    // data path, lsb first
    always_ff @(posedge clk_root) begin
        if (busy_q && tick_q == '0) begin
            if (bit_q >= 4'd1 && bit_q <= 4'd8) begin
                shift_q <= {rxd_s, shift_q[7:1]};
            end
            if (bit_q == 4'd9) begin
                rx_byte <= shift_q;
            end
        end
    end

endmodule

`default_nettype wire

//--- scan/matrix_scan.sv
/*
 * row and bit plane sequencer, pixel clock, latch, output enable, row address
 */
`timescale 1ns/1ps
`default_nettype none

`include "led_matrix_config.svh"

module matrix_scan import led_matrix_pkg::*; (
    input  logic        clk_root,
    input  logic        arst_n,
    output logic        load_start,
    output col_addr_t   load_col,
    output row_addr_t   scan_row,
    output plane_mask_t plane_mask,
    output logic        clk_pixel,
    output logic        row_latch,
    output logic        oe_n,
    output row_addr_t   row_addr
);

    localparam int DIV_W   = $clog2(`LM_SCAN_DIV);
    localparam int PLANE_W = $clog2(`LM_PLANES);
    localparam int SHOW_W  = $clog2(`LM_SHOW_BASE << (`LM_PLANES - 1)) + 1;

    logic [DIV_W-1:0]   div_q;
    logic               tick;
    scan_state_t        state_q;
    logic               phase_q;     // second tick of a column or latch
    col_addr_t          col_q;
    logic [PLANE_W-1:0] plane_q;
    logic [SHOW_W-1:0]  show_q;
    logic [SHOW_W-1:0]  show_len;

    assign tick       = div_q == DIV_W'(`LM_SCAN_DIV - 1);
    assign plane_mask = plane_mask_t'(1) << plane_q;
    assign show_len   = SHOW_W'(`LM_SHOW_BASE) << plane_q;

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            div_q      <= '0;
            state_q    <= SHIFT;
            phase_q    <= 1'b0;
            col_q      <= '0;
            plane_q    <= '0;
            scan_row   <= '0;
            show_q     <= '0;
            load_start <= 1'b0;
            load_col   <= '0;
            clk_pixel  <= 1'b0;
            row_latch  <= 1'b0;
            oe_n       <= 1'b1;
            row_addr   <= '0;
        end else begin
            div_q      <= tick ? '0 : div_q + 1'b1;
            load_start <= 1'b0;
            row_latch  <= 1'b0;
            if (tick) begin
                case (state_q)
                    SHIFT: begin
                        phase_q <= ~phase_q;
                        if (!phase_q) begin
                            load_start <= 1'b1;      // fetch this column
                            load_col   <= col_q;
                            clk_pixel  <= 1'b0;
                        end else begin
                            clk_pixel <= 1'b1;       // shift it in
                            col_q     <= col_q + 1'b1;
                            if (col_q == col_addr_t'(`LM_WIDTH - 1)) begin
                                state_q <= LATCH;
                            end
                        end
                    end
                    LATCH: begin
                        phase_q <= ~phase_q;
                        if (!phase_q) begin
                            clk_pixel <= 1'b0;
                        end else begin
                            row_latch <= 1'b1;
                            row_addr  <= scan_row;
                            show_q    <= '0;
                            state_q   <= SHOW;
                        end
                    end
                    SHOW: begin
                        if (show_q == show_len) begin
                            oe_n    <= 1'b1;
                            col_q   <= '0;
                            state_q <= SHIFT;
                            if (plane_q == PLANE_W'(`LM_PLANES - 1)) begin
                                plane_q <= '0;
                                if (scan_row == row_addr_t'(`LM_HALF_HEIGHT - 1)) begin
                                    scan_row <= '0;
                                end else begin
                                    scan_row <= scan_row + 1'b1;
                                end
                            end else begin
                                plane_q <= plane_q + 1'b1;
                            end
                        end else begin
                            oe_n   <= 1'b0;   // plane weight 2^p ticks
                            show_q <= show_q + 1'b1;
                        end
                    end
                    default: state_q <= SHIFT;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- scan/pixel_fetch.sv
/*
 * top and bottom pixel reads per column, plane bit select and enable masking
 */
`timescale 1ns/1ps
`default_nettype none

`include "led_matrix_config.svh"

module pixel_fetch import led_matrix_pkg::*; (
    input  logic        clk_root,
    input  logic        arst_n,
    input  logic        load_start,
    input  col_addr_t   load_col,
    input  row_addr_t   scan_row,
    input  plane_mask_t plane_mask,
    input  rgb_t        rgb_enable,
    input  plane_mask_t brightness_enable,
    output logic        fb_rd_en,
    output fb_addr_t    fb_rd_addr,
    input  pixel_t      fb_rd_data,
    output rgb_t        rgb_top,
    output rgb_t        rgb_bottom
);

    logic      pend1_q;   // bottom read issued, top byte arriving
    logic      pend2_q;   // bottom byte arriving
    col_addr_t col_q;
    row_addr_t row_q;
    pixel_t    top_q;
    fb_addr_t  top_addr;
    fb_addr_t  bottom_addr;

    // colour bit c of plane p is pixel bit 2c+p
    function automatic rgb_t split(input pixel_t px);
        rgb_t res;
        for (int c = 0; c < 3; c++) begin
            res[c] = |(px[2*c +: 2] & plane_mask & brightness_enable) & rgb_enable[c];
        end
        return res;
    endfunction

    assign top_addr    = fb_addr_t'(scan_row) * fb_addr_t'(`LM_WIDTH) + fb_addr_t'(load_col);
    assign bottom_addr = (fb_addr_t'(row_q) + fb_addr_t'(`LM_HALF_HEIGHT))
                         * fb_addr_t'(`LM_WIDTH) + fb_addr_t'(col_q);
    assign fb_rd_en    = load_start | pend1_q;
    assign fb_rd_addr  = load_start ? top_addr : bottom_addr;

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            pend1_q    <= 1'b0;
            pend2_q    <= 1'b0;
            rgb_top    <= '0;
            rgb_bottom <= '0;
        end else begin
            pend1_q <= load_start;
            pend2_q <= pend1_q;
            if (pend2_q) begin   // both halves change together
                rgb_top    <= split(top_q);
                rgb_bottom <= split(fb_rd_data);
            end
        end
    end

    always_ff @(posedge clk_root) begin
        if (load_start) begin
            col_q <= load_col;
            row_q <= scan_row;
        end
        if (pend1_q) begin
            top_q <= fb_rd_data;
        end
    end

endmodule

`default_nettype wire
